/* hdl/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    // ============================================================
    // Widths
    // ============================================================
    localparam int xlen           = 32;
    localparam int csr_addr_width = 12;
    localparam int zimm_width     = 5;

    // ============================================================
    // CSR addresses kept in this design
    // ============================================================
    typedef enum logic [csr_addr_width-1:0] {
        csr_mstatus   = 12'h300,
        csr_mie       = 12'h304,
        csr_mtvec     = 12'h305,
        csr_mscratch  = 12'h340,
        csr_mepc      = 12'h341,
        csr_mcause    = 12'h342,
        csr_mtval     = 12'h343,
        csr_mip       = 12'h344,
        csr_mcycle    = 12'hB00,
        csr_minstret  = 12'hB02,
        csr_mcycleh   = 12'hB80,
        csr_minstreth = 12'hB82,
        // Custom timer registers
        csr_mtime     = 12'hBC0,
        csr_mtimecmp  = 12'hBC1
    } csr_addr_e;

    // Software access operation, same encoding as the decode stage
    typedef enum logic [1:0] {
        op_none  = 2'b00,
        op_write = 2'b01,
        op_set   = 2'b10,
        op_clear = 2'b11
    } csr_op_e;

    // ============================================================
    // mcause codes
    // ============================================================
    localparam logic [xlen-1:0] cause_interrupt_flag      = 32'h8000_0000;
    localparam logic [xlen-1:0] cause_illegal_instruction = 32'h0000_0002;
    localparam logic [xlen-1:0] cause_breakpoint          = 32'h0000_0003;
    localparam logic [xlen-1:0] cause_misaligned_access   = 32'h0000_0004;
    localparam logic [xlen-1:0] cause_illegal_csr_access  = 32'h0000_000B;
    localparam logic [xlen-1:0] cause_machine_timer       = cause_interrupt_flag | 32'h7;

    // Bit positions
    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;
    localparam int mie_mtie_bit     = 7;
    localparam int mip_mtip_bit     = 7;

    // Every kept register comes out of reset at zero
    localparam logic [xlen-1:0] csr_reset_value = '0;

    // Read-modify-write for one register
    function automatic logic [xlen-1:0] apply_csr_op(
        input logic [xlen-1:0] old_value,
        input logic [xlen-1:0] operand,
        input csr_op_e         op
    );
        logic [xlen-1:0] new_value;
        case (op)
            op_write: new_value = operand;
            op_set:   new_value = old_value | operand;
            op_clear: new_value = old_value & ~operand;
            default:  new_value = old_value;
        endcase
        return new_value;
    endfunction

endpackage

`default_nettype wire

/* hdl/csr_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One software CSR access, shared by all register owners
interface csr_bus_if (
    input logic clk
);
    import csr_pkg::*;

    logic            wr_en;
    csr_addr_e       addr;   // also valid on reads
    csr_op_e         op;
    logic [xlen-1:0] wdata;

    // Clock only needed on the driving side for protocol checks
    modport master (
        input  clk,
        output wr_en, addr, op, wdata
    );

    modport owner (
        input wr_en, addr, op, wdata
    );

endinterface

`default_nettype wire

/* hdl/csr_access.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_access (
    input  logic                                wr_en,
    input  logic                                rd_en,
    input  csr_pkg::csr_addr_e                  addr,
    input  csr_pkg::csr_op_e                    op,
    input  logic                                imm_sel,
    input  logic [csr_pkg::zimm_width-1:0]      zimm,
    input  logic [csr_pkg::xlen-1:0]            rs1_data,
    csr_bus_if.master                           bus,
    input  logic                                cnt_rd_hit,
    input  logic [csr_pkg::xlen-1:0]            cnt_rd_data,
    input  logic                                trap_rd_hit,
    input  logic [csr_pkg::xlen-1:0]            trap_rd_data,
    output logic [csr_pkg::xlen-1:0]            rd_data
);
    import csr_pkg::*;

    // Operand select, immediate is zero extended
    logic [xlen-1:0] operand;

    assign operand = imm_sel ? {{(xlen-zimm_width){1'b0}}, zimm} : rs1_data;

    // Drive the shared access bus
    assign bus.wr_en = wr_en;
    assign bus.addr  = addr;
    assign bus.op    = op;
    assign bus.wdata = operand;

    // Read merge, owners do their own decode
    always_comb begin
        rd_data = '0;
        if (rd_en) begin
            if (cnt_rd_hit) begin
                rd_data = cnt_rd_data;
            end else if (trap_rd_hit) begin
                rd_data = trap_rd_data;
            end
        end
    end

    // A write with no operation means a broken decode upstream
    wr_op_valid: assert property (@(posedge bus.clk) wr_en |-> op != op_none);

endmodule

`default_nettype wire

/* hdl/csr_counters.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_counters (
    input  logic                      clk,
    input  logic                      rst,
    csr_bus_if.owner                  bus,
    input  logic                      valid_inst,
    output logic                      rd_hit,
    output logic [csr_pkg::xlen-1:0]  rd_data,
    output logic                      timer_pending
);
    import csr_pkg::*;

    // 64-bit counters, low half in the lower xlen bits
    logic [2*xlen-1:0] mcycle_q;
    logic [2*xlen-1:0] mcycle_n;
    logic [2*xlen-1:0] minstret_q;
    logic [2*xlen-1:0] minstret_n;
    logic [xlen-1:0]   mtime_q;
    logic [xlen-1:0]   mtimecmp_q;
    logic [xlen-1:0]   mtimecmp_n;

    // ============================================================
    // Next state
    // ============================================================
    always_comb begin
        // Hardware increments first, carry into high half for free
        mcycle_n   = mcycle_q + 1'b1;
        minstret_n = valid_inst ? minstret_q + 1'b1 : minstret_q;
        mtimecmp_n = mtimecmp_q;

        // Software write overrides the increment of that half
        if (bus.wr_en) begin
            case (bus.addr)
                csr_mcycle:
                    mcycle_n[xlen-1:0] = apply_csr_op(mcycle_q[xlen-1:0], bus.wdata, bus.op);
                csr_mcycleh:
                    mcycle_n[2*xlen-1:xlen] =
                        apply_csr_op(mcycle_q[2*xlen-1:xlen], bus.wdata, bus.op);
                csr_minstret:
                    minstret_n[xlen-1:0] =
                        apply_csr_op(minstret_q[xlen-1:0], bus.wdata, bus.op);
                csr_minstreth:
                    minstret_n[2*xlen-1:xlen] =
                        apply_csr_op(minstret_q[2*xlen-1:xlen], bus.wdata, bus.op);
                csr_mtimecmp:
                    mtimecmp_n = apply_csr_op(mtimecmp_q, bus.wdata, bus.op);
                // mtime is read only, writes dropped here
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle_q   <= {2{csr_reset_value}};
            minstret_q <= {2{csr_reset_value}};
            mtime_q    <= csr_reset_value;
            mtimecmp_q <= csr_reset_value;
        end else begin
            mcycle_q   <= mcycle_n;
            minstret_q <= minstret_n;
            mtime_q    <= mtime_q + 1'b1;
            mtimecmp_q <= mtimecmp_n;
        end
    end

    // Raw compare, enables qualified in the trap unit
    assign timer_pending = mtime_q >= mtimecmp_q;

    // Read decode
    always_comb begin
        rd_hit  = 1'b1;
        rd_data = '0;
        case (bus.addr)
            csr_mcycle:    rd_data = mcycle_q[xlen-1:0];
            csr_mcycleh:   rd_data = mcycle_q[2*xlen-1:xlen];
            csr_minstret:  rd_data = minstret_q[xlen-1:0];
            csr_minstreth: rd_data = minstret_q[2*xlen-1:xlen];
            csr_mtime:     rd_data = mtime_q;
            csr_mtimecmp:  rd_data = mtimecmp_q;
            default:       rd_hit  = 1'b0;
        endcase
    end

    // High half only moves on a low-half wrap unless software wrote it
    mcycleh_wrap_only: assert property (@(posedge clk) disable iff (rst)
        $changed(mcycle_q[2*xlen-1:xlen]) && !$past(rst) &&
        !$past(bus.wr_en && bus.addr == csr_mcycleh)
        |-> $past(mcycle_q[xlen-1:0]) == '1);

endmodule

`default_nettype wire

/* hdl/csr_trap_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_trap_unit (
    input  logic                      clk,
    input  logic                      rst,
    csr_bus_if.owner                  bus,
    input  logic                      timer_pending,
    input  logic                      illegal_instruction,
    input  logic                      misaligned_access,
    input  logic                      illegal_csr_access,
    input  logic                      breakpoint,
    input  logic                      timer_irq_taken,
    input  logic                      mret,
    input  logic [csr_pkg::xlen-1:0]  trap_pc,
    input  logic [csr_pkg::xlen-1:0]  trap_tval,
    output logic                      rd_hit,
    output logic [csr_pkg::xlen-1:0]  rd_data,
    output logic                      timer_irq_enable,
    output logic                      trap_jump_en,
    output logic [csr_pkg::xlen-1:0]  trap_jump_addr,
    output logic                      trap_return_en,
    output logic [csr_pkg::xlen-1:0]  trap_return_addr
);
    import csr_pkg::*;

    logic [xlen-1:0] mstatus_q, mstatus_n;
    logic [xlen-1:0] mie_q, mie_n;
    logic [xlen-1:0] mip_q, mip_n;
    logic [xlen-1:0] mtvec_q, mtvec_n;
    logic [xlen-1:0] mscratch_q, mscratch_n;
    logic [xlen-1:0] mepc_q, mepc_n;
    logic [xlen-1:0] mcause_q, mcause_n;
    logic [xlen-1:0] mtval_q, mtval_n;
    logic            exception;
    logic [xlen-1:0] exc_cause;
    logic            trap_event;

    // ============================================================
    // Exception priority
    // ============================================================
    always_comb begin
        exception = 1'b1;
        exc_cause = cause_breakpoint;
        if (breakpoint) begin
            exc_cause = cause_breakpoint;
        end else if (illegal_csr_access) begin
            exc_cause = cause_illegal_csr_access;
        end else if (misaligned_access) begin
            exc_cause = cause_misaligned_access;
        end else if (illegal_instruction) begin
            exc_cause = cause_illegal_instruction;
        end else begin
            exception = 1'b0;
        end
    end

    assign trap_event = exception | timer_irq_taken;

    // Timer qualified by global and local enable
    assign timer_irq_enable = timer_pending && mstatus_q[mstatus_mie_bit] &&
                              mie_q[mie_mtie_bit];

    // Redirect to fetch
    assign trap_jump_en     = trap_event;
    assign trap_jump_addr   = mtvec_q;
    assign trap_return_en   = mret;
    assign trap_return_addr = mepc_q;

    // ============================================================
    // Next state, hardware then software
    // ============================================================
    always_comb begin
        mstatus_n  = mstatus_q;
        mie_n      = mie_q;
        mip_n      = mip_q;
        mtvec_n    = mtvec_q;
        mscratch_n = mscratch_q;
        mepc_n     = mepc_q;
        mcause_n   = mcause_q;
        mtval_n    = mtval_q;

        // Sticky until software clears it
        if (timer_irq_enable) begin
            mip_n[mip_mtip_bit] = 1'b1;
        end

        if (exception) begin
            mcause_n = exc_cause;
            mepc_n   = trap_pc;
            mtval_n  = trap_tval;
        end else if (timer_irq_taken) begin
            mcause_n = cause_machine_timer;
            mepc_n   = trap_pc;
            // Save MIE, block nesting until mret
            mstatus_n[mstatus_mpie_bit] = mstatus_q[mstatus_mie_bit];
            mstatus_n[mstatus_mie_bit]  = 1'b0;
        end

        if (mret) begin
            mstatus_n[mstatus_mie_bit] = mstatus_q[mstatus_mpie_bit];
        end

        // Software lands last and wins
        if (bus.wr_en) begin
            case (bus.addr)
                csr_mstatus:  mstatus_n  = apply_csr_op(mstatus_q, bus.wdata, bus.op);
                csr_mie:      mie_n      = apply_csr_op(mie_q, bus.wdata, bus.op);
                csr_mip:      mip_n      = apply_csr_op(mip_q, bus.wdata, bus.op);
                csr_mtvec:    mtvec_n    = apply_csr_op(mtvec_q, bus.wdata, bus.op);
                csr_mscratch: mscratch_n = apply_csr_op(mscratch_q, bus.wdata, bus.op);
                csr_mepc:     mepc_n     = apply_csr_op(mepc_q, bus.wdata, bus.op);
                csr_mcause:   mcause_n   = apply_csr_op(mcause_q, bus.wdata, bus.op);
                csr_mtval:    mtval_n    = apply_csr_op(mtval_q, bus.wdata, bus.op);
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_q  <= csr_reset_value;
            mie_q      <= csr_reset_value;
            mip_q      <= csr_reset_value;
            mtvec_q    <= csr_reset_value;
            mscratch_q <= csr_reset_value;
            mepc_q     <= csr_reset_value;
            mcause_q   <= csr_reset_value;
            mtval_q    <= csr_reset_value;
        end else begin
            mstatus_q  <= mstatus_n;
            mie_q      <= mie_n;
            mip_q      <= mip_n;
            mtvec_q    <= mtvec_n;
            mscratch_q <= mscratch_n;
            mepc_q     <= mepc_n;
            mcause_q   <= mcause_n;
            mtval_q    <= mtval_n;
        end
    end

    // Read decode
    always_comb begin
        rd_hit  = 1'b1;
        rd_data = '0;
        case (bus.addr)
            csr_mstatus:  rd_data = mstatus_q;
            csr_mie:      rd_data = mie_q;
            csr_mip:      rd_data = mip_q;
            csr_mtvec:    rd_data = mtvec_q;
            csr_mscratch: rd_data = mscratch_q;
            csr_mepc:     rd_data = mepc_q;
            csr_mcause:   rd_data = mcause_q;
            csr_mtval:    rd_data = mtval_q;
            default:      rd_hit  = 1'b0;
        endcase
    end

    // Pipeline never retires mret alongside a faulting instruction
    mret_not_with_trap: assert property (@(posedge clk) disable iff (rst)
        mret |-> !trap_event);

endmodule

`default_nettype wire

/* hdl/core_csr.sv */
`timescale 1ns/1ps
`default_nettype none

module core_csr (
    input  logic                                  clk,
    input  logic                                  rst,
    // Software access from the pipeline
    input  logic                                  csr_wr_en,
    input  logic                                  csr_rd_en,
    input  logic [csr_pkg::csr_addr_width-1:0]    csr_addr,
    input  logic [1:0]                            csr_op,
    input  logic                                  csr_imm_sel,
    input  logic [csr_pkg::zimm_width-1:0]        csr_zimm,
    input  logic [csr_pkg::xlen-1:0]              csr_rs1_data,
    input  logic                                  valid_inst,
    // Trap events
    input  logic                                  illegal_instruction,
    input  logic                                  misaligned_access,
    input  logic                                  illegal_csr_access,
    input  logic                                  breakpoint,
    input  logic                                  timer_irq_taken,
    input  logic                                  mret,
    input  logic [csr_pkg::xlen-1:0]              trap_pc,
    input  logic [csr_pkg::xlen-1:0]              trap_tval,
    // Results
    output logic [csr_pkg::xlen-1:0]              csr_rd_data,
    output logic                                  timer_irq_enable,
    output logic                                  trap_jump_en,
    output logic [csr_pkg::xlen-1:0]              trap_jump_addr,
    output logic                                  trap_return_en,
    output logic [csr_pkg::xlen-1:0]              trap_return_addr
);
    import csr_pkg::*;

    logic            cnt_rd_hit;
    logic [xlen-1:0] cnt_rd_data;
    logic            trap_rd_hit;
    logic [xlen-1:0] trap_rd_data;
    logic            timer_pending;

    csr_bus_if bus (.clk(clk));

    // Unmapped addresses pass through the cast and miss every owner
    csr_access i_csr_access (
        .wr_en        (csr_wr_en),
        .rd_en        (csr_rd_en),
        .addr         (csr_addr_e'(csr_addr)),
        .op           (csr_op_e'(csr_op)),
        .imm_sel      (csr_imm_sel),
        .zimm         (csr_zimm),
        .rs1_data     (csr_rs1_data),
        .bus          (bus.master),
        .cnt_rd_hit   (cnt_rd_hit),
        .cnt_rd_data  (cnt_rd_data),
        .trap_rd_hit  (trap_rd_hit),
        .trap_rd_data (trap_rd_data),
        .rd_data      (csr_rd_data)
    );

    csr_counters i_csr_counters (
        .clk           (clk),
        .rst           (rst),
        .bus           (bus.owner),
        .valid_inst    (valid_inst),
        .rd_hit        (cnt_rd_hit),
        .rd_data       (cnt_rd_data),
        .timer_pending (timer_pending)
    );

    csr_trap_unit i_csr_trap_unit (
        .clk                 (clk),
        .rst                 (rst),
        .bus                 (bus.owner),
        .timer_pending       (timer_pending),
        .illegal_instruction (illegal_instruction),
        .misaligned_access   (misaligned_access),
        .illegal_csr_access  (illegal_csr_access),
        .breakpoint          (breakpoint),
        .timer_irq_taken     (timer_irq_taken),
        .mret                (mret),
        .trap_pc             (trap_pc),
        .trap_tval           (trap_tval),
        .rd_hit              (trap_rd_hit),
        .rd_data             (trap_rd_data),
        .timer_irq_enable    (timer_irq_enable),
        .trap_jump_en        (trap_jump_en),
        .trap_jump_addr      (trap_jump_addr),
        .trap_return_en      (trap_return_en),
        .trap_return_addr    (trap_return_addr)
    );

endmodule

`default_nettype wire

/* test/csr_tb_table.svh */
`ifndef CSR_TB_TABLE_SVH
`define CSR_TB_TABLE_SVH

localparam int table_len = 18;

// Columns: op, address, imm select, zimm, rs1 data, expected read-back
function automatic row_t table_row(input int idx);
    row_t row;
    case (idx)
        // mscratch, register and immediate forms
        0:  row = {op_write, csr_mscratch, 1'b0, 5'h00, 32'hA5A5_0F0F, 32'hA5A5_0F0F};
        1:  row = {op_set,   csr_mscratch, 1'b0, 5'h00, 32'h0000_F0F0, 32'hA5A5_FFFF};
        2:  row = {op_clear, csr_mscratch, 1'b0, 5'h00, 32'hA500_00FF, 32'h00A5_FF00};
        3:  row = {op_set,   csr_mscratch, 1'b1, 5'h1F, 32'hFFFF_FFFF, 32'h00A5_FF1F};
        4:  row = {op_clear, csr_mscratch, 1'b1, 5'h03, 32'hFFFF_FFFF, 32'h00A5_FF1C};
        // mtvec, ends at the trap vector used later
        5:  row = {op_write, csr_mtvec,    1'b0, 5'h00, 32'h8000_0100, 32'h8000_0100};
        6:  row = {op_set,   csr_mtvec,    1'b1, 5'h11, 32'h0000_0000, 32'h8000_0111};
        7:  row = {op_clear, csr_mtvec,    1'b0, 5'h00, 32'h0000_0111, 32'h8000_0000};
        8:  row = {op_write, csr_mtvec,    1'b0, 5'h00, 32'h0000_2000, 32'h0000_2000};
        // mepc
        9:  row = {op_write, csr_mepc,     1'b0, 5'h00, 32'h1234_5678, 32'h1234_5678};
        10: row = {op_clear, csr_mepc,     1'b0, 5'h00, 32'h0000_00FF, 32'h1234_5600};
        11: row = {op_set,   csr_mepc,     1'b1, 5'h1F, 32'h0000_0000, 32'h1234_561F};
        12: row = {op_write, csr_mepc,     1'b1, 5'h0A, 32'hDEAD_BEEF, 32'h0000_000A};
        // Unmapped, reads as zero
        13: row = {op_write, 12'h7C0,      1'b0, 5'h00, 32'hDEAD_BEEF, 32'h0000_0000};
        14: row = {op_set,   12'h123,      1'b0, 5'h00, 32'hFFFF_FFFF, 32'h0000_0000};
        // Zero set keeps value, shows the unmapped writes went nowhere
        15: row = {op_set,   csr_mscratch, 1'b0, 5'h00, 32'h0000_0000, 32'h00A5_FF1C};
        16: row = {op_set,   csr_mtvec,    1'b0, 5'h00, 32'h0000_0000, 32'h0000_2000};
        17: row = {op_set,   csr_mepc,     1'b0, 5'h00, 32'h0000_0000, 32'h0000_000A};
        default: row = '0;
    endcase
    return row;
endfunction

`endif

/* test/core_csr_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module core_csr_tb;
    import csr_pkg::*;

    localparam logic [31:0] lfsr_seed     = 32'h200e_ed0d;
    localparam int          sample_delay  = 2;
    localparam int          cycle_gap     = 7;
    localparam int          timer_offset  = 20;
    localparam int          timer_timeout = 64;
    localparam int          exc_cases     = 8;
    // Last mtvec value written by the table
    localparam logic [31:0] mtvec_value   = 32'h0000_2000;
    // Exception masks {breakpoint, illegal csr, misaligned, illegal instr} taken low nibble first
    localparam logic [4*exc_cases-1:0] exc_mask_list =
        {4'b0011, 4'b0101, 4'b0111, 4'b1111, 4'b1000, 4'b0100, 4'b0010, 4'b0001};

    typedef struct packed {
        logic [1:0]  op;
        logic [11:0] addr;
        logic        imm_sel;
        logic [4:0]  zimm;
        logic [31:0] rs1_data;
        logic [31:0] expected;
    } row_t;

    `include "csr_tb_table.svh"

    logic        clk;
    logic        rst;
    logic        csr_wr_en;
    logic        csr_rd_en;
    logic [11:0] csr_addr;
    logic [1:0]  csr_op;
    logic        csr_imm_sel;
    logic [4:0]  csr_zimm;
    logic [31:0] csr_rs1_data;
    logic        valid_inst;
    logic        illegal_instruction;
    logic        misaligned_access;
    logic        illegal_csr_access;
    logic        breakpoint;
    logic        timer_irq_taken;
    logic        mret;
    logic [31:0] trap_pc;
    logic [31:0] trap_tval;
    logic [31:0] csr_rd_data;
    logic        timer_irq_enable;
    logic        trap_jump_en;
    logic [31:0] trap_jump_addr;
    logic        trap_return_en;
    logic [31:0] trap_return_addr;

    logic [31:0] lfsr_state = lfsr_seed;
    int          checks = 0;
    int          errors = 0;

    core_csr i_core_csr (.*);

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ============================================================
    // Helpers
    // ============================================================
    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] random_word(input int nbits);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int b = 0; b < nbits; b++) begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value      = {value[30:0], feedback};
        end
        return value;
    endfunction

    // Breakpoint beats illegal csr access beats misaligned beats illegal instr
    function automatic logic [31:0] expected_cause(input logic [3:0] mask);
        if (mask[3]) begin
            return 32'd3;
        end else if (mask[2]) begin
            return 32'd11;
        end else if (mask[1]) begin
            return 32'd4;
        end else begin
            return 32'd2;
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAIL t=%0t %s got=%h expected=%h", $time, name, got, expected);
        end
    endtask

    // Drop all strobes and return op to none
    task automatic clear_strobes;
        csr_wr_en           = 1'b0;
        csr_rd_en           = 1'b0;
        csr_op              = op_none;
        valid_inst          = 1'b0;
        illegal_instruction = 1'b0;
        misaligned_access   = 1'b0;
        illegal_csr_access  = 1'b0;
        breakpoint          = 1'b0;
        timer_irq_taken     = 1'b0;
        mret                = 1'b0;
    endtask

    task automatic idle_cycle;
        @(negedge clk);
        clear_strobes();
    endtask

    // Write lands on the next rising edge
    task automatic write_csr(input logic [1:0] op, input logic [11:0] addr,
                             input logic imm_sel, input logic [4:0] zimm,
                             input logic [31:0] rs1);
        @(negedge clk);
        clear_strobes();
        csr_wr_en    = 1'b1;
        csr_op       = op;
        csr_addr     = addr;
        csr_imm_sel  = imm_sel;
        csr_zimm     = zimm;
        csr_rs1_data = rs1;
    endtask

    // Combinational read sampled in the middle of the low phase
    task automatic read_csr(input logic [11:0] addr, output logic [31:0] data);
        @(negedge clk);
        clear_strobes();
        csr_rd_en = 1'b1;
        csr_addr  = addr;
        #sample_delay;
        data = csr_rd_data;
    endtask

    task automatic pulse_valid_inst;
        @(negedge clk);
        clear_strobes();
        valid_inst = 1'b1;
    endtask

    // Redirect must show in the same cycle as the event
    task automatic raise_trap(input logic [3:0] mask, input logic timer,
                              input logic [31:0] pc, input logic [31:0] tval);
        @(negedge clk);
        clear_strobes();
        breakpoint          = mask[3];
        illegal_csr_access  = mask[2];
        misaligned_access   = mask[1];
        illegal_instruction = mask[0];
        timer_irq_taken     = timer;
        trap_pc             = pc;
        trap_tval           = tval;
        #sample_delay;
        check_value("trap_jump_en", trap_jump_en, 1);
        check_value("trap_jump_addr", trap_jump_addr, mtvec_value);
    endtask

    // ============================================================
    // Stimulus
    // ============================================================
    initial begin : stimulus
        row_t        row;
        logic [31:0] rd;
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] value;
        logic [31:0] gap;
        logic [31:0] pc;
        logic [31:0] tval;
        logic [3:0]  mask;
        logic        seen;
        int          pulses;

        clear_strobes();
        rst          = 1'b1;
        csr_addr     = '0;
        csr_imm_sel  = 1'b0;
        csr_zimm     = '0;
        csr_rs1_data = '0;
        trap_pc      = '0;
        trap_tval    = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #sample_delay;
        check_value("timer_irq_enable", timer_irq_enable, 0);
        check_value("trap_jump_en", trap_jump_en, 0);
        check_value("trap_return_en", trap_return_en, 0);

        // Table of writes with each read back one cycle later
        for (int i = 0; i < table_len; i++) begin
            row = table_row(i);
            write_csr(row.op, row.addr, row.imm_sel, row.zimm, row.rs1_data);
            read_csr(row.addr, rd);
            check_value($sformatf("csr_rd_data[%03h]", row.addr), rd, row.expected);
        end

        // ============================================================
        // Counters
        // ============================================================
        read_csr(csr_mcycle, first);
        repeat (cycle_gap - 1) idle_cycle();
        read_csr(csr_mcycle, second);
        check_value("mcycle delta", second - first, cycle_gap);

        // Random spacing of retire pulses
        read_csr(csr_minstret, first);
        pulses = 0;
        for (int i = 0; i < 12; i++) begin
            if (random_word(1)) begin
                pulse_valid_inst();
                pulses++;
            end else begin
                idle_cycle();
            end
        end
        read_csr(csr_minstret, second);
        check_value("minstret delta", second - first, pulses);

        value = random_word(32);
        write_csr(op_write, csr_mcycle, 1'b0, 5'h00, value);
        gap = random_word(3);
        repeat (gap) idle_cycle();
        read_csr(csr_mcycle, rd);
        check_value("mcycle after write", rd, value + gap);

        // ============================================================
        // Single and combined exceptions
        // ============================================================
        for (int i = 0; i < exc_cases; i++) begin
            mask = exc_mask_list[4*i +: 4];
            pc   = random_word(32);
            tval = random_word(32);
            raise_trap(mask, 1'b0, pc, tval);
            read_csr(csr_mcause, rd);
            check_value("mcause", rd, expected_cause(mask));
            read_csr(csr_mepc, rd);
            check_value("mepc", rd, pc);
            read_csr(csr_mtval, rd);
            check_value("mtval", rd, tval);
        end

        // Timer taken together with an exception loses to the exception
        pc   = random_word(32);
        tval = random_word(32);
        raise_trap(4'b0001, 1'b1, pc, tval);
        read_csr(csr_mcause, rd);
        check_value("mcause", rd, 32'd2);
        read_csr(csr_mtval, rd);
        check_value("mtval", rd, tval);

        // ============================================================
        // Timer interrupt
        // ============================================================
        // Compare value goes in before the enables so nothing fires early
        read_csr(csr_mtime, rd);
        write_csr(op_write, csr_mtimecmp, 1'b0, 5'h00, rd + timer_offset);
        write_csr(op_set, csr_mstatus, 1'b1, 5'h08, 32'h0);
        write_csr(op_set, csr_mie, 1'b0, 5'h00, 32'h0000_0080);
        seen = 1'b0;
        for (int i = 0; i < timer_timeout && !seen; i++) begin
            idle_cycle();
            #sample_delay;
            seen = timer_irq_enable;
        end
        if (!seen) begin
            errors++;
            $display("Timer interrupt enable did not rise within %0d cycles", timer_timeout);
        end
        read_csr(csr_mip, rd);
        check_value("mip", rd, 32'h0000_0080);

        // Taken interrupt leaves mtval at the last exception value
        pc = random_word(32);
        raise_trap(4'b0000, 1'b1, pc, random_word(32));
        read_csr(csr_mcause, rd);
        check_value("mcause", rd, 32'h8000_0007);
        read_csr(csr_mstatus, rd);
        check_value("mstatus after timer trap", rd, 32'h0000_0080);
        read_csr(csr_mtval, rd);
        check_value("mtval", rd, tval);

        // Return restores MIE from MPIE
        @(negedge clk);
        clear_strobes();
        mret = 1'b1;
        #sample_delay;
        check_value("trap_return_en", trap_return_en, 1);
        check_value("trap_return_addr", trap_return_addr, pc);
        read_csr(csr_mstatus, rd);
        check_value("mstatus after mret", rd, 32'h0000_0088);

        idle_cycle();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+test
hdl/csr_pkg.sv
hdl/csr_bus_if.sv
hdl/csr_access.sv
hdl/csr_counters.sv
hdl/csr_trap_unit.sv
hdl/core_csr.sv
test/core_csr_tb.sv
